/* hdl/irq_apb_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module irq_apb_slave (
    input  wire logic                       clk_i,
    input  wire logic                       reset_i,

    input  wire logic                       psel_i,
    input  wire logic                       penable_i,
    input  wire logic                       pwrite_i,
    input  wire logic [irq_pkg::ADDR_W-1:0] paddr_i,
    input  wire irq_pkg::word_t             pwdata_i,
    input  wire logic [irq_pkg::STRB_W-1:0] pstrb_i,
    output irq_pkg::word_t                  prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,

    irq_reg_if.master                       reg_o
);
    import irq_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_e;

    apb_state_e            state_q;
    apb_state_e            state_d;
    logic [REG_ADDR_W-1:0] word_addr;
    logic                  access;
    logic                  mapped;

    assign word_addr = paddr_i[ADDR_W-1:REG_ADDR_LSB];
    assign mapped    = word_addr <= REG_CLAIM;

    // an access cycle only counts right after a setup cycle
    assign access = (state_q == SETUP) && psel_i && penable_i;

    always_comb begin
        state_d = IDLE;
        if (access) begin
            state_d = ACCESS;
        end else if (psel_i && !penable_i) begin
            state_d = SETUP;                    // also covers back to back transfers
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // unmapped words never reach the register block
    assign reg_o.wr_en = access && pwrite_i && mapped;
    assign reg_o.rd_en = access && !pwrite_i && mapped;
    assign reg_o.addr  = reg_addr_e'(word_addr);
    assign reg_o.wdata = pwdata_i;
    assign reg_o.wstrb = pstrb_i;

    assign prdata_o  = reg_o.rdata;             // zero unless rd_en is up
    assign pready_o  = 1'b1;                    // no wait states
    assign pslverr_o = access && !mapped;

endmodule

`default_nettype wire

/* hdl/irq_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module irq_ctrl_top (
    input  wire logic                       clk_i,
    input  wire logic                       reset_i,

    input  wire logic                       psel_i,
    input  wire logic                       penable_i,
    input  wire logic                       pwrite_i,
    input  wire logic [irq_pkg::ADDR_W-1:0] paddr_i,
    input  wire irq_pkg::word_t             pwdata_i,
    input  wire logic [irq_pkg::STRB_W-1:0] pstrb_i,
    output irq_pkg::word_t                  prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,

    input  wire irq_pkg::word_t             irq_i,
    output logic                            irq_o,
    output irq_pkg::irq_id_t                irq_id_o
);
    import irq_pkg::*;

    word_t edge_vec;                            // one cycle rising edges
    word_t active;                              // registered pending & enable

    irq_reg_if i_reg_if ();

    irq_apb_slave i_apb_slave (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pstrb_i   (pstrb_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .reg_o     (i_reg_if.master)
    );

    irq_edge_capture i_edge_capture (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .irq_i   (irq_i),
        .edge_o  (edge_vec)
    );

    irq_pending_regs i_pending_regs (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .edge_i   (edge_vec),
        .reg_i    (i_reg_if.target),
        .irq_i    (irq_o),                      // fed back for CLAIM reads
        .irq_id_i (irq_id_o),
        .active_o (active)
    );

    irq_priority_encoder i_priority_encoder (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .active_i (active),
        .irq_o    (irq_o),
        .irq_id_o (irq_id_o)
    );

endmodule

`default_nettype wire

/* hdl/irq_edge_capture.sv */
`timescale 1ns/1ns
`default_nettype none

module irq_edge_capture (
    input  wire logic           clk_i,
    input  wire logic           reset_i,

    input  wire irq_pkg::word_t irq_i,
    output irq_pkg::word_t      edge_o
);
    import irq_pkg::*;

    word_t sync1_q;                             // first metastability flop
    word_t sync2_q;
    word_t prev_q;                              // last synchronized level
    word_t edge_q;

    // lines already high in reset give one edge once released,
    // since the whole chain starts from zero
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
            edge_q  <= '0;
        end else begin
            sync1_q <= irq_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            edge_q  <= sync2_q & ~prev_q;       // rising edge, one cycle wide
        end
    end

    assign edge_o = edge_q;

endmodule

`default_nettype wire

/* hdl/irq_pending_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module irq_pending_regs (
    input  wire logic             clk_i,
    input  wire logic             reset_i,

    input  wire irq_pkg::word_t   edge_i,
    irq_reg_if.target             reg_i,

    input  wire logic             irq_i,
    input  wire irq_pkg::irq_id_t irq_id_i,
    output irq_pkg::word_t        active_o
);
    import irq_pkg::*;

    word_t pending_q;
    word_t enable_q;
    word_t active_q;
    word_t pending_d;
    word_t enable_d;
    word_t strb_mask;
    word_t clr_mask;
    word_t claim_word;
    word_t rd_mux;

    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            strb_mask[b*8 +: 8] = {8{reg_i.wstrb[b]}};
        end
    end

    always_comb begin
        clr_mask = '0;
        enable_d = enable_q;
        if (reg_i.wr_en && reg_i.addr == REG_PENDING) begin
            clr_mask = reg_i.wdata & strb_mask;
        end
        if (reg_i.wr_en && reg_i.addr == REG_ENABLE) begin
            enable_d = (enable_q & ~strb_mask) | (reg_i.wdata & strb_mask);
        end
        // a new edge beats a clear on the same bit
        pending_d = (pending_q & ~clr_mask) | edge_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= '0;
            enable_q  <= ENABLE_RESET;
            active_q  <= '0;
        end else begin
            pending_q <= pending_d;
            enable_q  <= enable_d;
            active_q  <= pending_d & enable_d;  // tracks both in the same edge
        end
    end

    assign active_o = active_q;

    always_comb begin
        claim_word                  = '0;
        claim_word[IRQ_ID_W-1:0]    = irq_id_i;
        claim_word[CLAIM_VALID_BIT] = irq_i;
    end

    always_comb begin
        case (reg_i.addr)
            REG_PENDING: rd_mux = pending_q;
            REG_ENABLE:  rd_mux = enable_q;
            REG_ACTIVE:  rd_mux = active_q;
            REG_CLAIM:   rd_mux = claim_word;
            default:     rd_mux = '0;
        endcase
    end

    assign reg_i.rdata = reg_i.rd_en ? rd_mux : '0;

endmodule

`default_nettype wire

/* hdl/irq_pkg.sv */
`default_nettype none

package irq_pkg;

    localparam int NUM_IRQ  = 32;
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 6;                // bits 5:2 select the word
    localparam int STRB_W   = DATA_W / 8;
    localparam int IRQ_ID_W = $clog2(NUM_IRQ);

    localparam int REG_ADDR_LSB = 2;           // byte offset inside a word
    localparam int REG_ADDR_W   = 4;

    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [IRQ_ID_W-1:0] irq_id_t;

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_PENDING = 4'd0,                     // read, write one to clear
        REG_ENABLE  = 4'd1,                     // read / write
        REG_ACTIVE  = 4'd2,                     // pending & enable
        REG_CLAIM   = 4'd3                      // winning line + valid
    } reg_addr_e;

    localparam word_t ENABLE_RESET    = '1;    // every line enabled out of reset
    localparam int    CLAIM_VALID_BIT = 31;

endpackage

`default_nettype wire

/* hdl/irq_priority_encoder.sv */
`timescale 1ns/1ns
`default_nettype none

module irq_priority_encoder (
    input  wire logic           clk_i,
    input  wire logic           reset_i,

    input  wire irq_pkg::word_t active_i,
    output logic                irq_o,
    output irq_pkg::irq_id_t    irq_id_o
);
    import irq_pkg::*;

    irq_id_t win_id;
    logic    any_active;
    logic    irq_q;
    irq_id_t irq_id_q;

    // scan from the top so the lowest set bit is written last
    always_comb begin
        win_id = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (active_i[i]) begin
                win_id = irq_id_t'(i);
            end
        end
    end

    assign any_active = |active_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_q    <= 1'b0;
            irq_id_q <= '0;
        end else begin
            irq_q    <= any_active;
            irq_id_q <= win_id;                 // zero when nothing is active
        end
    end

    assign irq_o    = irq_q;
    assign irq_id_o = irq_id_q;

endmodule

`default_nettype wire

/* hdl/irq_reg_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface irq_reg_if;
    import irq_pkg::*;

    logic              wr_en;       // one cycle per write access
    logic              rd_en;       // one cycle per read access
    reg_addr_e         addr;
    word_t             wdata;
    logic [STRB_W-1:0] wstrb;
    word_t             rdata;       // combinational from addr

    modport master (
        output wr_en,
        output rd_en,
        output addr,
        output wdata,
        output wstrb,
        input  rdata
    );

    modport target (
        input  wr_en,
        input  rd_en,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata
    );

endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the interrupt controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=irq_ctrl_sim
log_file=sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module irq_ctrl_tb \
    -Mdir "$build_dir" \
    -o "$sim_exe"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Everything OK" "$log_file"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

/* sources.f */
hdl/irq_pkg.sv
hdl/irq_reg_if.sv
hdl/irq_apb_slave.sv
hdl/irq_edge_capture.sv
hdl/irq_pending_regs.sv
hdl/irq_priority_encoder.sv
hdl/irq_ctrl_top.sv
verif/irq_ctrl_chk.sv
verif/irq_ctrl_tb.sv

/* verif/irq_ctrl_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module irq_ctrl_chk (
    input wire logic           clk_i,
    input wire logic           reset_i,
    input wire logic           psel_i,
    input wire logic           penable_i,
    input wire logic           pready_i,
    input wire logic           pslverr_i,
    input wire logic           irq_req_i,
    input wire irq_pkg::word_t active_i
);

    // zero wait states, so every access cycle completes
    pready_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
        (psel_i && penable_i) |-> pready_i)
        else $error("pready low in an access cycle");

    slverr_only_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
        pslverr_i |-> (psel_i && penable_i))
        else $error("pslverr high outside an access cycle");

    // request is registered from the active vector
    irq_follows_active: assert property (@(posedge clk_i) disable iff (reset_i)
        (active_i == '0) |=> !irq_req_i)
        else $error("irq high one cycle after an empty active vector");

    irq_low_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !irq_req_i)
        else $error("irq high in the cycle after reset");

endmodule

bind irq_ctrl_top irq_ctrl_chk i_chk (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .irq_req_i (irq_o),
    .active_i  (active)
);

`default_nettype wire

/* verif/irq_ctrl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module irq_ctrl_tb;
    import irq_pkg::*;

    localparam int         RESET_CYCLES = 10;
    localparam logic [5:0] A_PENDING    = 6'h00;
    localparam logic [5:0] A_ENABLE     = 6'h04;
    localparam logic [5:0] A_ACTIVE     = 6'h08;
    localparam logic [5:0] A_CLAIM      = 6'h0C;

    typedef enum logic [2:0] {OP_RAISE, OP_LOWER, OP_WRITE, OP_READ, OP_CHECK} op_e;

    typedef struct packed {
        op_e        op;
        logic [5:0] addr;
        word_t      data;
        logic [3:0] strb;
        word_t      exp_rdata;
        logic       exp_slverr;
        logic       exp_irq;
        irq_id_t    exp_id;
    } step_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [5:0] paddr;
    word_t      pwdata;
    logic [3:0] pstrb;
    word_t      prdata;
    logic       pready;
    logic       pslverr;
    word_t      irq_lines;
    logic       irq;
    irq_id_t    irq_id;

    step_t  steps[$];
    word_t  m_lines;                            // model of raw lines, pending and enable
    word_t  m_pend;
    word_t  m_en;
    integer seed;
    int     pass_cnt;
    int     fail_cnt;
    logic   table_ready = 1'b0;

    irq_ctrl_top i_dut (
        .clk_i     (clk),
        .reset_i   (reset),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .pstrb_i   (pstrb),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .irq_i     (irq_lines),
        .irq_o     (irq),
        .irq_id_o  (irq_id)
    );

    always #5 clk = ~clk;

    function automatic word_t byte_mask(input logic [3:0] strb);
        word_t m;
        m = '0;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                m[b*8 +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    // isolate the lowest set bit, its log2 is the line number
    function automatic irq_id_t lowest_line(input word_t mask);
        return irq_id_t'($clog2(mask & (~mask + 32'd1)));
    endfunction

    task automatic push_step(input op_e op, input logic [5:0] addr, input word_t data,
                             input logic [3:0] strb, input word_t exp_rdata);
        step_t s;
        s.op         = op;
        s.addr       = addr;
        s.data       = data;
        s.strb       = strb;
        s.exp_rdata  = exp_rdata;
        s.exp_slverr = addr[5:2] > 4'd3;
        s.exp_irq    = |(m_pend & m_en);
        s.exp_id     = lowest_line(m_pend & m_en);
        steps.push_back(s);
    endtask

    task automatic raise_lines(input word_t mask);
        m_pend  = m_pend | (mask & ~m_lines);   // only rising lines latch
        m_lines = m_lines | mask;
        push_step(OP_RAISE, 6'h00, mask, 4'h0, '0);
    endtask

    task automatic drop_lines(input word_t mask);
        m_lines = m_lines & ~mask;
        push_step(OP_LOWER, 6'h00, mask, 4'h0, '0);
    endtask

    task automatic write_word(input logic [5:0] addr, input word_t data, input logic [3:0] strb);
        word_t bm;
        bm = byte_mask(strb);
        if (addr[5:2] == 4'd0) begin
            m_pend = m_pend & ~(data & bm);
        end else if (addr[5:2] == 4'd1) begin
            m_en = (m_en & ~bm) | (data & bm);
        end
        push_step(OP_WRITE, addr, data, strb, '0);
    endtask

    task automatic read_word(input logic [5:0] addr);
        word_t act;
        word_t rd;
        act = m_pend & m_en;
        case (addr[5:2])
            4'd0:    rd = m_pend;
            4'd1:    rd = m_en;
            4'd2:    rd = act;
            4'd3:    rd = (act != '0) ? {1'b1, 26'd0, lowest_line(act)} : '0;
            default: rd = '0;
        endcase
        push_step(OP_READ, addr, '0, 4'h0, rd);
    endtask

    task automatic expect_irq();
        push_step(OP_CHECK, 6'h00, '0, 4'h0, '0);
    endtask

    task automatic build_table();
        word_t mask;
        read_word(A_PENDING);                   // reset values
        read_word(A_ENABLE);
        read_word(A_ACTIVE);
        read_word(A_CLAIM);
        expect_irq();
        raise_lines(word_t'(1) << 5);           // single line
        expect_irq();
        read_word(A_PENDING);
        read_word(A_CLAIM);
        mask = $random(seed);
        if (mask == '0) begin
            mask = 32'h0000_0100;
        end
        raise_lines(mask);                      // random set of lines
        expect_irq();
        read_word(A_CLAIM);
        read_word(A_PENDING);
        read_word(A_ACTIVE);
        mask = $random(seed);
        write_word(A_ENABLE, mask, 4'b0101);
        read_word(A_ENABLE);
        read_word(A_ACTIVE);
        read_word(A_CLAIM);
        expect_irq();
        write_word(A_PENDING, 32'hffff_ffff, 4'hf);
        drop_lines(32'hffff_ffff);
        expect_irq();
        write_word(A_ENABLE, 32'hffff_ffff, 4'hf);
        raise_lines(word_t'(1) << 12);
        expect_irq();
        write_word(A_ENABLE, 32'h0000_0000, 4'b0010); // masks line 12
        read_word(A_ENABLE);
        read_word(A_PENDING);
        read_word(A_ACTIVE);
        expect_irq();
        raise_lines((word_t'(1) << 3) | (word_t'(1) << 20));
        expect_irq();                           // both edges latched before the clear
        write_word(A_PENDING, 32'hffff_ffff, 4'b0001);
        read_word(A_PENDING);
        expect_irq();
        write_word(A_PENDING, word_t'(1) << 20, 4'b0100);
        expect_irq();
        read_word(A_PENDING);
        drop_lines(word_t'(1) << 20);
        expect_irq();
        raise_lines(word_t'(1) << 20);          // new rise latches again
        expect_irq();
        read_word(A_PENDING);
        read_word(6'h10);                       // unmapped words
        write_word(6'h14, 32'hffff_ffff, 4'hf);
        read_word(6'h3C);
        write_word(A_ACTIVE, 32'h0000_0000, 4'hf);
        write_word(A_CLAIM, 32'hffff_ffff, 4'hf);
        read_word(A_ENABLE);
        read_word(A_PENDING);
        read_word(A_ACTIVE);
        read_word(A_CLAIM);
        expect_irq();
    endtask

    task automatic apb_xfer(input logic wr, input logic [5:0] addr, input word_t wdata,
                            input logic [3:0] strb, output word_t rdata, output logic slverr,
                            output logic ready);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);                         // middle of the access cycle
        rdata  = prdata;
        slverr = pslverr;
        ready  = pready;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic run_step(input int idx);
        step_t s;
        word_t rdata;
        logic  slverr;
        logic  ready;
        logic  ok;
        s  = steps[idx];
        ok = 1'b1;
        case (s.op)
            OP_RAISE: begin
                @(posedge clk);
                irq_lines <= irq_lines | s.data;
            end
            OP_LOWER: begin
                @(posedge clk);
                irq_lines <= irq_lines & ~s.data;
            end
            OP_WRITE, OP_READ: begin
                apb_xfer(s.op == OP_WRITE, s.addr, s.data, s.strb, rdata, slverr, ready);
                assert (ready == 1'b1) else begin
                    $display("Mismatch pready_o: expected %h, got %h", 1'b1, ready);
                    ok = 1'b0;
                end
                assert (slverr == s.exp_slverr) else begin
                    $display("Mismatch pslverr_o: expected %h, got %h", s.exp_slverr, slverr);
                    ok = 1'b0;
                end
                if (s.op == OP_READ) begin
                    assert (rdata == s.exp_rdata) else begin
                        $display("Mismatch prdata_o: expected %h, got %h", s.exp_rdata, rdata);
                        ok = 1'b0;
                    end
                end
            end
            OP_CHECK: begin
                repeat (6) @(posedge clk);
                @(negedge clk);
                assert (irq == s.exp_irq) else begin
                    $display("Mismatch irq_o: expected %h, got %h", s.exp_irq, irq);
                    ok = 1'b0;
                end
                assert (irq_id == s.exp_id) else begin
                    $display("Mismatch irq_id_o: expected %h, got %h", s.exp_id, irq_id);
                    ok = 1'b0;
                end
            end
            default: begin
                $display("unknown operation in test table entry %0d", idx);
                ok = 1'b0;
            end
        endcase
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("step %0d %s addr %h: %s", idx, s.op.name(), s.addr, ok ? "pass" : "FAIL");
    endtask

    initial begin
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pstrb     = '0;
        irq_lines = '0;
        seed      = 32'h2111_b877;
        pass_cnt  = 0;
        fail_cnt  = 0;
        m_lines   = '0;
        m_pend    = '0;
        m_en      = '1;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(i);
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog, 20 cycles per table entry plus reset
    initial begin
        wait (table_ready);
        repeat (steps.size() * 20 + RESET_CYCLES) @(posedge clk);
        $display("timeout: the test table did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
